// ==== verilog/riscv_isa_pkg.sv ====
// RV32I ISA definitions
// Widths, major opcodes and the funct3/funct7 codes of the integer subset
`default_nettype none

package riscv_isa_pkg;

  // Data and address width
  localparam int unsigned xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  // Major opcodes kept by the stage
  typedef enum logic [6:0] {
    opc_op     = 7'h33,
    opc_op_imm = 7'h13,
    opc_lui    = 7'h37,
    opc_auipc  = 7'h17,
    opc_branch = 7'h63,
    opc_jal    = 7'h6f
  } opcode_e;

  ////////////////////////////////////////
  // funct3 codes
  ////////////////////////////////////////

  // Register and immediate ALU ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct7: base ops, and the alternate form selecting sub and sra
  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt  = 7'b010_0000;

endpackage

`default_nettype wire

// ==== verilog/id_uop_pkg.sv ====
// Micro-op definitions for the decode/execute stage
// ALU operators, operand selects and the queued micro-op
`default_nettype none

package id_uop_pkg;

  // ALU operation, arithmetic first and compares last
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  // Operand A source
  typedef enum logic {
    op_a_reg,
    op_a_pc
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    op_b_reg,
    op_b_imm
  } op_b_sel_e;

  // One decoded instruction as it sits in the queue
  typedef struct packed {
    alu_op_e                  alu_op;
    op_a_sel_e                op_a_sel;
    op_b_sel_e                op_b_sel;
    riscv_isa_pkg::word_t     imm;
    riscv_isa_pkg::word_t     pc;
    riscv_isa_pkg::reg_addr_t rs1;
    riscv_isa_pkg::reg_addr_t rs2;
    riscv_isa_pkg::reg_addr_t rd;
    logic                     rf_we;
    logic                     is_branch;
    logic                     is_jump;
    logic                     illegal;
  } uop_t;

  // Queue depth unless the top level says otherwise
  localparam int unsigned default_queue_depth = 4;

endpackage

`default_nettype wire

// ==== verilog/id_decoder.sv ====
// RV32I instruction decoder
// Turns instruction and PC into a registered micro-op and pushes it to the
// queue, spending one credit per push
`timescale 1ns/1ps
`default_nettype none

module id_decoder #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_valid_i,
  input  riscv_isa_pkg::word_t instr_rdata_i,
  input  riscv_isa_pkg::word_t pc_i,
  input  logic                 credit_i,
  output logic                 instr_ready_o,
  output logic                 push_o,
  output id_uop_pkg::uop_t     push_uop_o
);

  localparam int unsigned cnt_w = $clog2(DEPTH + 1);

  logic [cnt_w-1:0]     credit_cnt_q;
  logic                 push_q;
  id_uop_pkg::uop_t     uop_q;
  id_uop_pkg::uop_t     uop_d;
  logic                 dec_illegal;
  logic                 accept;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  riscv_isa_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 to ALU op for the base (funct7 = 0) register and immediate forms
  function automatic id_uop_pkg::alu_op_e base_alu_op(input logic [2:0] f3);
    case (f3)
      riscv_isa_pkg::f3_sll:     return id_uop_pkg::alu_sll;
      riscv_isa_pkg::f3_slt:     return id_uop_pkg::alu_slt;
      riscv_isa_pkg::f3_sltu:    return id_uop_pkg::alu_sltu;
      riscv_isa_pkg::f3_xor:     return id_uop_pkg::alu_xor;
      riscv_isa_pkg::f3_srl_sra: return id_uop_pkg::alu_srl;
      riscv_isa_pkg::f3_or:      return id_uop_pkg::alu_or;
      riscv_isa_pkg::f3_and:     return id_uop_pkg::alu_and;
      default:                   return id_uop_pkg::alu_add;
    endcase
  endfunction

  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  ////////////////////////////////////////
  // Immediates, all sign extended
  ////////////////////////////////////////
  assign imm_i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                  instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u = {instr_rdata_i[31:12], 12'b0};
  assign imm_j = {{11{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[19:12],
                  instr_rdata_i[20], instr_rdata_i[30:21], 1'b0};

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////
  always_comb begin
    uop_d          = '0;
    uop_d.pc       = pc_i;
    uop_d.rs1      = instr_rdata_i[19:15];
    uop_d.rs2      = instr_rdata_i[24:20];
    uop_d.rd       = instr_rdata_i[11:7];
    uop_d.alu_op   = id_uop_pkg::alu_add;
    uop_d.op_a_sel = id_uop_pkg::op_a_reg;
    uop_d.op_b_sel = id_uop_pkg::op_b_reg;
    // Opcodes outside the subset take the S layout
    uop_d.imm      = imm_s;
    dec_illegal    = 1'b0;

    case (riscv_isa_pkg::opcode_e'(instr_rdata_i[6:0]))
      riscv_isa_pkg::opc_op: begin
        uop_d.rf_we = 1'b1;
        if (funct7 == riscv_isa_pkg::f7_base) begin
          uop_d.alu_op = base_alu_op(funct3);
        end else if (funct7 == riscv_isa_pkg::f7_alt && funct3 == riscv_isa_pkg::f3_add_sub) begin
          uop_d.alu_op = id_uop_pkg::alu_sub;
        end else if (funct7 == riscv_isa_pkg::f7_alt && funct3 == riscv_isa_pkg::f3_srl_sra) begin
          uop_d.alu_op = id_uop_pkg::alu_sra;
        end else begin
          dec_illegal = 1'b1;
        end
      end
      riscv_isa_pkg::opc_op_imm: begin
        uop_d.rf_we    = 1'b1;
        uop_d.op_b_sel = id_uop_pkg::op_b_imm;
        uop_d.imm      = imm_i;
        uop_d.alu_op   = base_alu_op(funct3);
        // Shift amounts live in imm[4:0], upper bits pick the shift kind
        if (funct3 == riscv_isa_pkg::f3_sll) begin
          dec_illegal = (funct7 != riscv_isa_pkg::f7_base);
        end else if (funct3 == riscv_isa_pkg::f3_srl_sra) begin
          if (funct7 == riscv_isa_pkg::f7_alt) begin
            uop_d.alu_op = id_uop_pkg::alu_sra;
          end else if (funct7 != riscv_isa_pkg::f7_base) begin
            dec_illegal = 1'b1;
          end
        end
      end
      riscv_isa_pkg::opc_lui: begin
        // x0 as operand A turns the add into a plain immediate load
        uop_d.rf_we    = 1'b1;
        uop_d.rs1      = '0;
        uop_d.op_b_sel = id_uop_pkg::op_b_imm;
        uop_d.imm      = imm_u;
      end
      riscv_isa_pkg::opc_auipc: begin
        uop_d.rf_we    = 1'b1;
        uop_d.op_a_sel = id_uop_pkg::op_a_pc;
        uop_d.op_b_sel = id_uop_pkg::op_b_imm;
        uop_d.imm      = imm_u;
      end
      riscv_isa_pkg::opc_branch: begin
        uop_d.is_branch = 1'b1;
        uop_d.imm       = imm_b;
        case (funct3)
          riscv_isa_pkg::f3_beq:  uop_d.alu_op = id_uop_pkg::alu_eq;
          riscv_isa_pkg::f3_bne:  uop_d.alu_op = id_uop_pkg::alu_ne;
          riscv_isa_pkg::f3_blt:  uop_d.alu_op = id_uop_pkg::alu_lt;
          riscv_isa_pkg::f3_bge:  uop_d.alu_op = id_uop_pkg::alu_ge;
          riscv_isa_pkg::f3_bltu: uop_d.alu_op = id_uop_pkg::alu_ltu;
          riscv_isa_pkg::f3_bgeu: uop_d.alu_op = id_uop_pkg::alu_geu;
          default:                dec_illegal  = 1'b1;
        endcase
      end
      riscv_isa_pkg::opc_jal: begin
        // ALU forms the target, rd gets PC plus 4 in execute
        uop_d.rf_we    = 1'b1;
        uop_d.is_jump  = 1'b1;
        uop_d.op_a_sel = id_uop_pkg::op_a_pc;
        uop_d.op_b_sel = id_uop_pkg::op_b_imm;
        uop_d.imm      = imm_j;
      end
      default: dec_illegal = 1'b1;
    endcase

    // Illegal ops must not write or redirect
    if (dec_illegal) begin
      uop_d.rf_we     = 1'b0;
      uop_d.is_branch = 1'b0;
      uop_d.is_jump   = 1'b0;
    end
    uop_d.illegal = dec_illegal;
  end

  ////////////////////////////////////////
  // Credits and output register
  ////////////////////////////////////////

  // Ready needs a credit beyond the one owed by the micro-op in the register
  assign instr_ready_o = credit_cnt_q > cnt_w'(push_q);
  assign accept        = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_cnt_q <= cnt_w'(DEPTH);
      push_q       <= 1'b0;
    end else begin
      // Spend on push, refill on return, both may hit in one cycle
      credit_cnt_q <= credit_cnt_q - cnt_w'(push_q) + cnt_w'(credit_i);
      push_q       <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      uop_q <= uop_d;
    end
  end

  assign push_o     = push_q;
  assign push_uop_o = uop_q;

endmodule

`default_nettype wire

// ==== verilog/uop_queue.sv ====
// Micro-op FIFO between decoder and execute
// Circular buffer with one credit returned to the decoder per pop
`timescale 1ns/1ps
`default_nettype none

module uop_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  id_uop_pkg::uop_t push_uop_i,
  input  logic             pop_i,
  output logic             uop_valid_o,
  output id_uop_pkg::uop_t uop_o,
  output logic             credit_o
);

  localparam int unsigned ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned cnt_w = $clog2(DEPTH + 1);

  id_uop_pkg::uop_t mem_q [DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             credit_q;

  // Pointer step, wraps for depths that are not a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Storage, no full check since the producer only pushes on credit
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_uop_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q  <= count_q + cnt_w'(push_i) - cnt_w'(pop_i);
      // One-cycle credit per popped slot
      credit_q <= pop_i;
    end
  end

  assign uop_valid_o = count_q != '0;
  assign uop_o       = mem_q[rd_ptr_q];
  assign credit_o    = credit_q;

endmodule

`default_nettype wire

// ==== verilog/id_execute.sv ====
// Execute block of the decode/execute stage
// Register file, operand muxes, ALU and branch/jump resolution; taken
// branches hold for a second cycle before the redirect
`timescale 1ns/1ps
`default_nettype none

module id_execute (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     uop_valid_i,
  input  id_uop_pkg::uop_t         uop_i,
  output logic                     pop_o,
  output logic                     rf_we_o,
  output riscv_isa_pkg::reg_addr_t rf_waddr_o,
  output riscv_isa_pkg::word_t     rf_wdata_o,
  output logic                     pc_set_o,
  output riscv_isa_pkg::word_t     pc_target_o,
  output logic                     illegal_insn_o
);

  typedef enum logic {
    first_cycle,
    branch_cycle
  } ex_state_e;

  ex_state_e            state_q, state_d;
  riscv_isa_pkg::word_t rf_q [31:1];
  riscv_isa_pkg::word_t rs1_data, rs2_data;
  riscv_isa_pkg::word_t op_a, op_b;
  riscv_isa_pkg::word_t alu_result;
  riscv_isa_pkg::word_t wr_data;
  id_uop_pkg::alu_op_e  alu_op;
  logic                 cmp_result;
  logic                 in_branch_cycle;
  logic                 branch_hold;
  logic                 rf_wr_en;
  logic                 rf_we_q, pc_set_q, illegal_q;

  ////////////////////////////////////////
  // Register file and operand muxes
  ////////////////////////////////////////

  // x0 reads as zero and is never stored
  assign rs1_data = (uop_i.rs1 == '0) ? '0 : rf_q[uop_i.rs1];
  assign rs2_data = (uop_i.rs2 == '0) ? '0 : rf_q[uop_i.rs2];

  // Second branch cycle reuses the ALU for PC plus B-immediate
  assign in_branch_cycle = state_q == branch_cycle;
  assign op_a   = (in_branch_cycle || uop_i.op_a_sel == id_uop_pkg::op_a_pc) ?
                  uop_i.pc : rs1_data;
  assign op_b   = (in_branch_cycle || uop_i.op_b_sel == id_uop_pkg::op_b_imm) ?
                  uop_i.imm : rs2_data;
  assign alu_op = in_branch_cycle ? id_uop_pkg::alu_add : uop_i.alu_op;

  ////////////////////////////////////////
  // ALU and compare
  ////////////////////////////////////////
  always_comb begin
    alu_result = '0;
    cmp_result = 1'b0;
    case (alu_op)
      id_uop_pkg::alu_add:  alu_result = op_a + op_b;
      id_uop_pkg::alu_sub:  alu_result = op_a - op_b;
      id_uop_pkg::alu_sll:  alu_result = op_a << op_b[4:0];
      id_uop_pkg::alu_srl:  alu_result = op_a >> op_b[4:0];
      id_uop_pkg::alu_sra:  alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
      id_uop_pkg::alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      id_uop_pkg::alu_sltu: alu_result = {31'b0, op_a < op_b};
      id_uop_pkg::alu_xor:  alu_result = op_a ^ op_b;
      id_uop_pkg::alu_or:   alu_result = op_a | op_b;
      id_uop_pkg::alu_and:  alu_result = op_a & op_b;
      // Branch compares only set the decision
      id_uop_pkg::alu_eq:   cmp_result = op_a == op_b;
      id_uop_pkg::alu_ne:   cmp_result = op_a != op_b;
      id_uop_pkg::alu_lt:   cmp_result = $signed(op_a) < $signed(op_b);
      id_uop_pkg::alu_ge:   cmp_result = $signed(op_a) >= $signed(op_b);
      id_uop_pkg::alu_ltu:  cmp_result = op_a < op_b;
      id_uop_pkg::alu_geu:  cmp_result = op_a >= op_b;
      default:              alu_result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Branch FSM and pop
  ////////////////////////////////////////

  // Taken branch stays in the queue head for one more cycle
  assign branch_hold = uop_valid_i & ~in_branch_cycle & uop_i.is_branch & cmp_result;
  assign pop_o       = uop_valid_i & ~branch_hold;

  always_comb begin
    state_d = state_q;
    case (state_q)
      first_cycle:  if (branch_hold) state_d = branch_cycle;
      branch_cycle: if (pop_o) state_d = first_cycle;
      default:      state_d = first_cycle;
    endcase
  end

  // State register doubles as the flopped compare result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= first_cycle;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Write-back and result outputs
  ////////////////////////////////////////

  // Jumps link PC plus 4, everything else writes the ALU result
  assign wr_data  = uop_i.is_jump ? uop_i.pc + 32'd4 : alu_result;
  assign rf_wr_en = pop_o & uop_i.rf_we;

  always_ff @(posedge clk_i) begin
    if (rf_wr_en && uop_i.rd != '0) begin
      rf_q[uop_i.rd] <= wr_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rf_we_q   <= 1'b0;
      pc_set_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      rf_we_q   <= rf_wr_en;
      pc_set_q  <= pop_o & (uop_i.is_jump | in_branch_cycle);
      illegal_q <= pop_o & uop_i.illegal;
    end
  end

  // Payload of the reported event, only meaningful with its strobe
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      rf_waddr_o  <= uop_i.rd;
      rf_wdata_o  <= wr_data;
      pc_target_o <= alu_result;
    end
  end

  assign rf_we_o        = rf_we_q;
  assign pc_set_o       = pc_set_q;
  assign illegal_insn_o = illegal_q;

endmodule

`default_nettype wire

// ==== verilog/id_stage_top.sv ====
// Trace-driven RV32I decode/execute stage
// Decoder feeds a credit-controlled micro-op queue, which feeds execute
`timescale 1ns/1ps
`default_nettype none

module id_stage_top #(
  parameter int unsigned DEPTH = id_uop_pkg::default_queue_depth
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     instr_valid_i,
  input  riscv_isa_pkg::word_t     instr_rdata_i,
  input  riscv_isa_pkg::word_t     pc_i,
  output logic                     instr_ready_o,
  output logic                     rf_we_o,
  output riscv_isa_pkg::reg_addr_t rf_waddr_o,
  output riscv_isa_pkg::word_t     rf_wdata_o,
  output logic                     pc_set_o,
  output riscv_isa_pkg::word_t     pc_target_o,
  output logic                     illegal_insn_o
);

  // Decoder to queue
  logic             push;
  id_uop_pkg::uop_t push_uop;
  logic             credit;

  // Queue to execute
  logic             uop_valid;
  id_uop_pkg::uop_t uop;
  logic             pop;

  id_decoder #(
    .DEPTH(DEPTH)
  ) i_decoder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_valid_i(instr_valid_i),
    .instr_rdata_i(instr_rdata_i),
    .pc_i         (pc_i),
    .credit_i     (credit),
    .instr_ready_o(instr_ready_o),
    .push_o       (push),
    .push_uop_o   (push_uop)
  );

  uop_queue #(
    .DEPTH(DEPTH)
  ) i_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (push),
    .push_uop_i (push_uop),
    .pop_i      (pop),
    .uop_valid_o(uop_valid),
    .uop_o      (uop),
    .credit_o   (credit)
  );

  id_execute i_execute (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .uop_valid_i   (uop_valid),
    .uop_i         (uop),
    .pop_o         (pop),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o),
    .pc_set_o      (pc_set_o),
    .pc_target_o   (pc_target_o),
    .illegal_insn_o(illegal_insn_o)
  );

endmodule

`default_nettype wire

// ==== tb/id_stage_assert.sv ====
// Concurrent checks on the decode/execute stage
// Credit bounds, queue handshake, redirect spacing and reset state
`timescale 1ns/1ps
`default_nettype none

module id_stage_assert #(
  parameter int unsigned DEPTH = 4
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic [$clog2(DEPTH+1)-1:0]   credit_cnt_i,
  input logic                         push_i,
  input logic                         credit_i,
  input logic                         uop_valid_i,
  input logic                         pop_i,
  input logic                         instr_ready_i,
  input logic                         rf_we_i,
  input logic                         pc_set_i,
  input logic                         illegal_insn_i
);

  // Failed assertion count
  int unsigned fail_cnt = 0;

  // Credits never exceed the queue depth
  credit_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_i <= DEPTH)
    else begin
      $error("Credit count %0d is outside 0..%0d", credit_cnt_i, DEPTH);
      fail_cnt++;
    end

  // A push always spends a credit that exists, so the count never wraps below zero
  push_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> credit_cnt_i != '0)
    else begin
      $error("Push with no credit left");
      fail_cnt++;
    end

  pop_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> uop_valid_i)
    else begin
      $error("Pop from an empty queue");
      fail_cnt++;
    end

  // At least one quiet cycle between redirects
  redirect_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else begin
      $error("Redirect on two cycles in a row");
      fail_cnt++;
    end

  reset_quiet: assert property (@(negedge clk_i)
    !rst_ni |-> instr_ready_i && !rf_we_i && !pc_set_i && !illegal_insn_i &&
                !push_i && !credit_i && !uop_valid_i)
    else begin
      $error("Stage not idle during reset");
      fail_cnt++;
    end

endmodule

bind id_stage_top id_stage_assert #(
  .DEPTH(DEPTH)
) i_id_stage_assert (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .credit_cnt_i  (i_decoder.credit_cnt_q),
  .push_i        (push),
  .credit_i      (credit),
  .uop_valid_i   (uop_valid),
  .pop_i         (pop),
  .instr_ready_i (instr_ready_o),
  .rf_we_i       (rf_we_o),
  .pc_set_i      (pc_set_o),
  .illegal_insn_i(illegal_insn_o)
);

`default_nettype wire

// ==== tb/tb_id_stage.sv ====
// Testbench for the RV32I decode/execute stage
// Replays a golden instruction trace and matches every result event in order
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  localparam int max_lines    = 64;
  localparam int words        = 5;
  localparam int reset_cycles = 10;
  localparam int drain_cycles = 20;

  // Word offsets within one golden line
  localparam int f_instr = 0;
  localparam int f_pc    = 1;
  localparam int f_kind  = 2;
  localparam int f_addr  = 3;
  localparam int f_data  = 4;

  localparam logic [31:0] kind_none     = 32'd0;
  localparam logic [31:0] kind_write    = 32'd1;
  localparam logic [31:0] kind_redirect = 32'd2;
  localparam logic [31:0] kind_illegal  = 32'd3;
  localparam logic [31:0] no_line       = 32'hffff_ffff;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     instr_valid_i;
  riscv_isa_pkg::word_t     instr_rdata_i;
  riscv_isa_pkg::word_t     pc_i;
  logic                     instr_ready_o;
  logic                     rf_we_o;
  riscv_isa_pkg::reg_addr_t rf_waddr_o;
  riscv_isa_pkg::word_t     rf_wdata_o;
  logic                     pc_set_o;
  riscv_isa_pkg::word_t     pc_target_o;
  logic                     illegal_insn_o;

  logic [31:0] golden_mem [0:max_lines*words-1];
  int          n_lines       = 0;
  bit          golden_loaded = 1'b0;
  bit          stall_seen    = 1'b0;
  int          exp_q[$];
  int          value_errs    = 0;
  int          event_errs    = 0;

  id_stage_top i_id_stage_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_rdata_i (instr_rdata_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o),
    .pc_set_o      (pc_set_o),
    .pc_target_o   (pc_target_o),
    .illegal_insn_o(illegal_insn_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_write(input int line, input riscv_isa_pkg::reg_addr_t exp_addr,
                             input riscv_isa_pkg::word_t exp_data);
    if (rf_waddr_o !== exp_addr) begin
      value_errs++;
      $display("ERR rf_waddr_o line %0d: expected 0x%h, actual 0x%h", line, exp_addr,
               rf_waddr_o);
    end
    if (rf_wdata_o !== exp_data) begin
      value_errs++;
      $display("ERR rf_wdata_o line %0d: expected 0x%h, actual 0x%h", line, exp_data,
               rf_wdata_o);
    end
  endtask

  task automatic check_redirect(input int line, input riscv_isa_pkg::word_t exp_target);
    if (pc_target_o !== exp_target) begin
      value_errs++;
      $display("ERR pc_target_o line %0d: expected 0x%h, actual 0x%h", line, exp_target,
               pc_target_o);
    end
  endtask

  task automatic check_illegal(input int line, input logic exp_flag);
    if (illegal_insn_o !== exp_flag) begin
      value_errs++;
      $display("ERR illegal_insn_o line %0d: expected 0x%h, actual 0x%h", line, exp_flag,
               illegal_insn_o);
    end
  endtask

  // Pairs one output event with the oldest pending expectation
  task automatic match_event();
    int          line;
    logic [31:0] kind;
    logic        is_jal;
    if (exp_q.size() == 0) begin
      event_errs++;
      $display("Output event came with no instruction left to match it");
    end else begin
      line   = exp_q.pop_front();
      kind   = golden_mem[line*words + f_kind];
      is_jal = golden_mem[line*words + f_instr][6:0] == riscv_isa_pkg::opc_jal;
      if (kind == kind_write) begin
        if (!rf_we_o || pc_set_o) begin
          event_errs++;
          $display("Line %0d expected a register write but another event came", line);
        end else begin
          check_write(line, golden_mem[line*words + f_addr][4:0],
                      golden_mem[line*words + f_data]);
        end
      end else if (kind == kind_redirect) begin
        // Jumps also link, branches only redirect
        if (!pc_set_o || rf_we_o != is_jal) begin
          event_errs++;
          $display("Line %0d expected a redirect but another event came", line);
        end else begin
          check_redirect(line, golden_mem[line*words + f_addr]);
          if (is_jal) begin
            check_write(line, golden_mem[line*words + f_instr][11:7],
                        golden_mem[line*words + f_data]);
          end
        end
      end else if (rf_we_o || pc_set_o) begin
        event_errs++;
        $display("Line %0d expected an illegal flag alone but a write or redirect came", line);
      end
      check_illegal(line, kind == kind_illegal);
    end
  endtask

  // Holds one instruction until the stage takes it
  task automatic drive_instr(input int line);
    instr_valid_i = 1'b1;
    instr_rdata_i = golden_mem[line*words + f_instr];
    pc_i          = golden_mem[line*words + f_pc];
    while (!instr_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////

  // Output pulses last one cycle, so each is seen at exactly one falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!instr_ready_o) begin
        stall_seen = 1'b1;
      end
      if (rf_we_o || pc_set_o || illegal_insn_o) begin
        match_event();
      end
    end
  end

  initial begin
    wait (golden_loaded);
    repeat (n_lines * 8 + reset_cycles + drain_cycles) @(posedge clk_i);
    $display("Timeout with %0d results not seen", exp_q.size());
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [15:0] lfsr;
    logic [1:0]  gap;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_rdata_i = '0;
    pc_i          = '0;
    lfsr          = 16'd33375;

    // Unused lines keep the marker in their kind word
    for (int i = 0; i < max_lines*words; i++) begin
      golden_mem[i] = no_line;
    end
    $readmemh("tb/id_stage_golden.txt", golden_mem);
    while (n_lines < max_lines && golden_mem[n_lines*words + f_kind] != no_line) begin
      if (golden_mem[n_lines*words + f_kind] != kind_none) begin
        exp_q.push_back(n_lines);
      end
      n_lines++;
    end
    if (n_lines == 0) begin
      event_errs++;
      $display("Golden file holds no instructions");
    end
    golden_loaded = 1'b1;

    repeat (reset_cycles) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < n_lines; i++) begin
      // Branches go back to back so taken runs fill the queue
      if (golden_mem[i*words + f_instr][6:0] != riscv_isa_pkg::opc_branch) begin
        lfsr   = lfsr_next(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        gap[1] = lfsr[0];
        repeat (gap) @(negedge clk_i);
      end
      drive_instr(i);
    end

    while (exp_q.size() != 0) @(negedge clk_i);
    // Quiet tail catches events nobody asked for
    repeat (drain_cycles / 2) @(negedge clk_i);

    if (!stall_seen) begin
      event_errs++;
      $display("Taken branch run never pulled instr_ready_o low");
    end
    if (!instr_ready_o) begin
      event_errs++;
      $display("instr_ready_o did not recover once the stage drained");
    end

    $display("Errors: %0d value, %0d event, %0d assertion", value_errs, event_errs,
             i_id_stage_top.i_id_stage_assert.fail_cnt);
    if (value_errs + event_errs + i_id_stage_top.i_id_stage_assert.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/riscv_isa_pkg.sv
verilog/id_uop_pkg.sv
verilog/id_decoder.sv
verilog/uop_queue.sv
verilog/id_execute.sv
verilog/id_stage_top.sv
tb/id_stage_assert.sv
tb/tb_id_stage.sv

// ==== tb/id_stage_golden.txt ====
// instr pc kind addr data, all hex; kind 0 none, 1 write (addr = rd),
// 2 redirect (addr = target, data = link for jal), 3 illegal
00500093 00000100 1 01 00000005
ffd00113 00000104 1 02 fffffffd
002081b3 00000108 1 03 00000002
40208233 0000010c 1 04 00000008
001122b3 00000110 1 05 00000001
00113333 00000114 1 06 00000000
401153b3 00000118 1 07 ffffffff
00415413 0000011c 1 08 0fffffff
00309493 00000120 1 09 00000028
0f04c513 00000124 1 0a 000000d8
003565b3 00000128 1 0b 000000da
00f5f613 0000012c 1 0c 0000000a
00c006b3 00000130 1 0d 0000000a
12345737 00000134 1 0e 12345000
00001797 00000138 1 0f 00001138
020000ef 0000013c 2 0000015c 00000140
0000a283 0000015c 3 00 00000000
021082b3 00000160 3 00 00000000
00028813 00000164 1 10 00000001
00318463 00000168 2 00000170 00000000
00209463 00000170 2 00000178 00000000
00314463 00000178 2 00000180 00000000
0021d463 00000180 2 00000188 00000000
0021e463 00000188 2 00000190 00000000
fe3178e3 00000190 2 00000180 00000000
00208463 00000180 0 00 00000000
00319463 00000184 0 00 00000000
0021c463 00000188 0 00 00000000
00315463 0000018c 0 00 00000000
00316463 00000190 0 00 00000000
0021f463 00000194 0 00 00000000
7ff80893 00000198 1 11 00000800
